// File: Makefile
VERILATOR = verilator
VFLAGS = --binary --timing -Wno-fatal -j 0
LINT_FLAGS = --lint-only -Wall --timing
TOP = tb_fc_top
RTL_TOP = fc_top
FILELIST = fc_top.f
OBJ_DIR = obj_dir
PASS_MSG = ** PASS **

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: fc_argmax.sv
`timescale 1ns/10ps
`include "fc_cfg.svh"

module fc_argmax (
  input  logic          clk,
  input  logic          rstn,
  input  logic          compute_start,
  input  logic          m_tvalid,
  input  logic          m_tready,
  input  fc_pkg::word_t m_tdata,
  output fc_pkg::idx_t  max_idx
);
  import fc_pkg::*;

  localparam elem_t ELEM_MIN = {1'b1, {(`FC_BYTE_W-1){1'b0}}};

  elem_t max_val;
  // Output index of byte 0 in the current word
  idx_t word_base;
  elem_t nxt_val;
  idx_t nxt_idx;

  // Later lanes win ties
  always_comb begin
    elem_t v;
    nxt_val = max_val;
    nxt_idx = max_idx;
    for (int i = 0; i < `FC_LANES; i++) begin
      v = elem_t'(m_tdata[i*`FC_BYTE_W +: `FC_BYTE_W]);
      if (v >= nxt_val) begin
        nxt_val = v;
        nxt_idx = word_base + idx_t'(i);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn || compute_start) begin
      max_val <= ELEM_MIN;
      max_idx <= '0;
      word_base <= '0;
    end else if (m_tvalid && m_tready) begin
      max_val <= nxt_val;
      max_idx <= nxt_idx;
      word_base <= word_base + idx_t'(`FC_LANES);
    end
  end

endmodule

// File: fc_cfg.svh
`ifndef FC_CFG_SVH
`define FC_CFG_SVH

// Stream word and element widths
`define FC_WORD_W 32
`define FC_BYTE_W 8

// One lane per byte of a stream word
`define FC_LANES 4

// MAC datapath
`define FC_ACC_W 28
`define FC_MUL_STAGES 8

// Buffer depth is 2**FC_ADDR_W words
`define FC_ADDR_W 10

// Byte count on the size port
`define FC_SIZE_W 21

// Quantizer right shift before saturation to int8
`define FC_OUT_SHIFT 6

// Argmax index width
`define FC_IDX_W 10

`endif

// File: fc_ctrl.sv
`timescale 1ns/10ps
`include "fc_cfg.svh"

module fc_ctrl (
  input  logic                  clk,
  input  logic                  rstn,
  input  fc_pkg::cmd_t          command,
  input  logic                  fc_start,
  input  logic [`FC_SIZE_W-1:0] size,
  input  logic                  s_tvalid,
  input  logic                  m_tvalid,
  input  logic                  m_tready,
  input  logic                  feed_busy,
  input  logic                  acc_done,
  output logic                  s_tready,
  output logic                  f_writedone,
  output logic                  b_writedone,
  output logic                  w_writedone,
  output logic                  f_we,
  output logic                  b_we,
  output logic [`FC_LANES-1:0]  w_we,
  output logic                  mem_en,
  output fc_pkg::addr_t         f_addr,
  output fc_pkg::addr_t         b_addr,
  output fc_pkg::addr_t         w_addr,
  output logic                  feed_load,
  output logic                  feed_first,
  output logic                  feed_last,
  output logic                  last_group,
  output logic                  compute_start,
  output logic                  fc_done
);
  import fc_pkg::*;

  localparam int LANES = `FC_LANES;
  localparam int RXW = `FC_SIZE_W - 2;

  state_t state;
  logic [RXW-1:0] rx_cnt;
  logic [RXW-1:0] rx_last;
  addr_t n_in_m1;
  addr_t n_grp_m1;
  // Column inside a weight row, or feature word during compute
  addr_t col;
  // Start of the current row block in each weight buffer
  addr_t base;
  addr_t grp;
  logic [$clog2(LANES)-1:0] lane;
  logic accept;
  logic rx_end;
  logic row_end;

  ////////////////////////////////////////////////////////////
  // Stream and buffer strobes
  ////////////////////////////////////////////////////////////
  assign s_tready = (state == ST_RX_F) || (state == ST_RX_B) || (state == ST_RX_W);
  assign accept = s_tvalid && s_tready;
  assign rx_end = accept && (rx_cnt == rx_last);
  assign row_end = (col == n_in_m1);

  assign f_we = accept && (state == ST_RX_F);
  assign b_we = accept && (state == ST_RX_B);
  assign w_we = (accept && state == ST_RX_W) ? (LANES'(1) << lane) : '0;
  assign mem_en = accept || (state == ST_READ);

  assign f_addr = col;
  assign b_addr = (state == ST_RX_B) ? col : grp;
  assign w_addr = base + col;

  // Feed handshake, one load per feature word
  assign feed_load = (state == ST_FEED) && !feed_busy;
  assign feed_first = (col == '0);
  assign feed_last = row_end;
  assign last_group = (grp == n_grp_m1);

  ////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstn) begin
      state <= ST_IDLE;
      f_writedone <= 1'b0;
      b_writedone <= 1'b0;
      w_writedone <= 1'b0;
      compute_start <= 1'b0;
      fc_done <= 1'b0;
      rx_cnt <= '0;
      col <= '0;
      base <= '0;
      grp <= '0;
      lane <= '0;
    end else begin
      compute_start <= 1'b0;
      fc_done <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (fc_start) begin
            rx_cnt <= '0;
            rx_last <= size[`FC_SIZE_W-1:2] - RXW'(1);
            col <= '0;
            base <= '0;
            lane <= '0;
            if (command[CMD_FEAT] && !f_writedone) begin
              n_in_m1 <= size[`FC_ADDR_W+1:2] - addr_t'(1);
              state <= ST_RX_F;
            end else if (command[CMD_BIAS] && !b_writedone) begin
              n_grp_m1 <= size[`FC_ADDR_W+1:2] - addr_t'(1);
              state <= ST_RX_B;
            end else if (command[CMD_WGT] && !w_writedone) begin
              state <= ST_RX_W;
            end
          end
        end
        ST_RX_F, ST_RX_B: begin
          if (accept) begin
            rx_cnt <= rx_cnt + RXW'(1);
            col <= col + addr_t'(1);
            if (rx_end) begin
              state <= ST_IDLE;
              if (state == ST_RX_F) begin
                f_writedone <= 1'b1;
              end else begin
                b_writedone <= 1'b1;
              end
            end
          end
        end
        ST_RX_W: begin
          if (accept) begin
            rx_cnt <= rx_cnt + RXW'(1);
            if (row_end) begin
              // Next row goes to the next lane
              col <= '0;
              lane <= lane + 1'b1;
              if (&lane) begin
                base <= base + n_in_m1 + addr_t'(1);
              end
            end else begin
              col <= col + addr_t'(1);
            end
            if (rx_end) begin
              w_writedone <= 1'b1;
              compute_start <= 1'b1;
              col <= '0;
              base <= '0;
              grp <= '0;
              state <= ST_READ;
            end
          end
        end
        ST_READ: begin
          state <= ST_FEED;
        end
        ST_FEED: begin
          if (!feed_busy) begin
            if (row_end) begin
              state <= ST_DRAIN;
            end else begin
              col <= col + addr_t'(1);
              state <= ST_READ;
            end
          end
        end
        ST_DRAIN: begin
          if (acc_done) begin
            state <= ST_SEND;
          end
        end
        ST_SEND: begin
          // Hold the next group until the result word is taken
          if (m_tvalid && m_tready) begin
            if (last_group) begin
              fc_done <= 1'b1;
              state <= ST_IDLE;
            end else begin
              grp <= grp + addr_t'(1);
              base <= base + n_in_m1 + addr_t'(1);
              col <= '0;
              state <= ST_READ;
            end
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

endmodule

// File: fc_feed.sv
`timescale 1ns/10ps
`include "fc_cfg.svh"

module fc_feed (
  input  logic          clk,
  input  logic          rstn,
  input  logic          feed_load,
  input  logic          feed_first,
  input  logic          feed_last,
  input  fc_pkg::word_t f_word,
  input  fc_pkg::word_t w_word0,
  input  fc_pkg::word_t w_word1,
  input  fc_pkg::word_t w_word2,
  input  fc_pkg::word_t w_word3,
  output logic          feed_busy,
  output logic          mac_valid,
  output logic          mac_first,
  output logic          mac_last,
  output fc_pkg::elem_t feat_byte,
  output fc_pkg::elem_t w_byte0,
  output fc_pkg::elem_t w_byte1,
  output fc_pkg::elem_t w_byte2,
  output fc_pkg::elem_t w_byte3
);
  import fc_pkg::*;

  localparam int CW = $clog2(`FC_LANES);

  word_t f_sh;
  word_t w_sh [`FC_LANES];
  logic [CW-1:0] bcnt;
  logic first_q;
  logic last_q;
  logic last_byte;

  assign last_byte = (bcnt == '1);
  assign feed_busy = mac_valid && !last_byte;
  assign mac_first = mac_valid && first_q && (bcnt == '0);
  assign mac_last = mac_valid && last_q && last_byte;

  // Low byte goes out first
  assign feat_byte = elem_t'(f_sh[`FC_BYTE_W-1:0]);
  assign w_byte0 = elem_t'(w_sh[0][`FC_BYTE_W-1:0]);
  assign w_byte1 = elem_t'(w_sh[1][`FC_BYTE_W-1:0]);
  assign w_byte2 = elem_t'(w_sh[2][`FC_BYTE_W-1:0]);
  assign w_byte3 = elem_t'(w_sh[3][`FC_BYTE_W-1:0]);

  always_ff @(posedge clk) begin
    if (!rstn) begin
      mac_valid <= 1'b0;
      bcnt <= '0;
    end else if (feed_load) begin
      mac_valid <= 1'b1;
      bcnt <= '0;
    end else if (mac_valid) begin
      bcnt <= bcnt + CW'(1);
      if (last_byte) begin
        mac_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (feed_load) begin
      f_sh <= f_word;
      w_sh[0] <= w_word0;
      w_sh[1] <= w_word1;
      w_sh[2] <= w_word2;
      w_sh[3] <= w_word3;
      first_q <= feed_first;
      last_q <= feed_last;
    end else begin
      f_sh <= f_sh >> `FC_BYTE_W;
      for (int i = 0; i < `FC_LANES; i++) begin
        w_sh[i] <= w_sh[i] >> `FC_BYTE_W;
      end
    end
  end

endmodule

// File: fc_mac.sv
`timescale 1ns/10ps
`include "fc_cfg.svh"

module fc_mac (
  input  logic          clk,
  input  logic          rstn,
  input  logic          mac_valid,
  input  logic          mac_first,
  input  logic          mac_last,
  input  fc_pkg::elem_t a,
  input  fc_pkg::elem_t b,
  output fc_pkg::acc_t  acc,
  output logic          acc_done
);
  import fc_pkg::*;

  localparam int NS = `FC_MUL_STAGES;

  // Flags ride alongside the product, bit k-1 marks stage k
  logic [NS-1:0] vld_p;
  logic [NS-1:0] first_p;
  logic [NS-1:0] last_p;
  logic [NS-2:0] sign_p;

  logic [7:0] a_mag;
  logic [7:0] b_mag;
  logic [7:0] pp [8];
  logic [5:0] lo1 [4];
  logic [2:0] h1x [4];
  logic [3:0] h1y [4];
  logic [9:0] l1 [4];
  logic [7:0] lo2 [2];
  logic [2:0] h2x [2];
  logic [4:0] h2y [2];
  logic [11:0] l2 [2];
  logic [9:0] lo3;
  logic [2:0] h3x;
  logic [6:0] h3y;
  logic [15:0] mag;
  logic signed [15:0] prod;

  assign a_mag = a[7] ? -a : a;
  assign b_mag = b[7] ? -b : b;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      vld_p <= '0;
    end else begin
      vld_p <= {vld_p[NS-2:0], mac_valid};
    end
  end

  ////////////////////////////////////////////////////////////
  // Unsigned 8x8 multiply, low half then high half per level
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    first_p <= {first_p[NS-2:0], mac_first};
    last_p <= {last_p[NS-2:0], mac_last};
    sign_p <= {sign_p[NS-3:0], a[7] ^ b[7]};
    // Stage 1
    for (int i = 0; i < 8; i++) begin
      pp[i] <= b_mag[i] ? a_mag : '0;
    end
    // Stages 2 and 3, pairs at shift 1
    for (int i = 0; i < 4; i++) begin
      lo1[i] <= 6'(pp[2*i][4:0]) + 6'({pp[2*i+1][3:0], 1'b0});
      h1x[i] <= pp[2*i][7:5];
      h1y[i] <= pp[2*i+1][7:4];
      l1[i] <= {5'(h1x[i]) + 5'(h1y[i]) + 5'(lo1[i][5]), lo1[i][4:0]};
    end
    // Stages 4 and 5, pairs at shift 2
    for (int j = 0; j < 2; j++) begin
      lo2[j] <= 8'(l1[2*j][6:0]) + 8'({l1[2*j+1][4:0], 2'b00});
      h2x[j] <= l1[2*j][9:7];
      h2y[j] <= l1[2*j+1][9:5];
      l2[j] <= {5'(h2x[j]) + h2y[j] + 5'(lo2[j][7]), lo2[j][6:0]};
    end
    // Stages 6 and 7, final pair at shift 4
    lo3 <= 10'(l2[0][8:0]) + 10'({l2[1][4:0], 4'b0000});
    h3x <= l2[0][11:9];
    h3y <= l2[1][11:5];
    mag <= {7'(h3x) + h3y + 7'(lo3[9]), lo3[8:0]};
    // Stage 8 restores the sign
    prod <= sign_p[NS-2] ? -$signed(mag) : $signed(mag);
  end

  ////////////////////////////////////////////////////////////
  // Accumulate
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (vld_p[NS-1]) begin
      acc <= first_p[NS-1] ? acc_t'(prod) : acc + acc_t'(prod);
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      acc_done <= 1'b0;
    end else begin
      acc_done <= vld_p[NS-1] && last_p[NS-1];
    end
  end

endmodule

// File: fc_pkg.sv
`include "fc_cfg.svh"

package fc_pkg;

  typedef logic [`FC_WORD_W-1:0] word_t;
  typedef logic signed [`FC_BYTE_W-1:0] elem_t;
  typedef logic signed [`FC_ACC_W-1:0] acc_t;
  typedef logic [`FC_ADDR_W-1:0] addr_t;
  typedef logic [`FC_IDX_W-1:0] idx_t;

  // One-hot load command
  typedef logic [2:0] cmd_t;
  localparam int CMD_FEAT = 0;
  localparam int CMD_BIAS = 1;
  localparam int CMD_WGT = 2;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_RX_F,
    ST_RX_B,
    ST_RX_W,
    ST_READ,
    ST_FEED,
    ST_DRAIN,
    ST_SEND
  } state_t;

endpackage

// File: fc_post.sv
`timescale 1ns/10ps
`include "fc_cfg.svh"

module fc_post (
  input  logic          clk,
  input  logic          rstn,
  input  logic          acc_done,
  input  fc_pkg::acc_t  acc0,
  input  fc_pkg::acc_t  acc1,
  input  fc_pkg::acc_t  acc2,
  input  fc_pkg::acc_t  acc3,
  input  fc_pkg::word_t bias_word,
  input  logic          last_group,
  input  logic          m_tready,
  output fc_pkg::word_t m_tdata,
  output logic          m_tvalid,
  output logic          m_tlast
);
  import fc_pkg::*;

  localparam int SAT_LO = `FC_OUT_SHIFT + `FC_BYTE_W - 1;

  acc_t lane_acc [`FC_LANES];
  word_t q_word;

  // ReLU, then shift and clamp to int8
  function automatic elem_t quant(acc_t r);
    if (r < 0) begin
      return '0;
    end
    if (|r[`FC_ACC_W-2:SAT_LO]) begin
      return elem_t'(2 ** (`FC_BYTE_W - 1) - 1);
    end
    return elem_t'(r[SAT_LO-1:`FC_OUT_SHIFT]);
  endfunction

  assign lane_acc = '{acc0, acc1, acc2, acc3};

  always_comb begin
    elem_t bias;
    for (int i = 0; i < `FC_LANES; i++) begin
      bias = elem_t'(bias_word[i*`FC_BYTE_W +: `FC_BYTE_W]);
      q_word[i*`FC_BYTE_W +: `FC_BYTE_W] = quant(lane_acc[i] + acc_t'(bias));
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      m_tvalid <= 1'b0;
      m_tlast <= 1'b0;
    end else if (acc_done) begin
      m_tvalid <= 1'b1;
      m_tlast <= last_group;
    end else if (m_tvalid && m_tready) begin
      m_tvalid <= 1'b0;
      m_tlast <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (acc_done) begin
      m_tdata <= q_word;
    end
  end

endmodule

// File: fc_sram.sv
`timescale 1ns/10ps
`include "fc_cfg.svh"

module fc_sram (
  input  logic          clk,
  input  logic          en,
  input  logic          we,
  input  fc_pkg::addr_t addr,
  input  fc_pkg::word_t din,
  output fc_pkg::word_t dout
);
  import fc_pkg::*;

  word_t mem [0:(1 << `FC_ADDR_W)-1];

  // Read data lands one cycle after an enabled read
  always_ff @(posedge clk) begin
    if (en) begin
      if (we) begin
        mem[addr] <= din;
      end else begin
        dout <= mem[addr];
      end
    end
  end

endmodule

// File: fc_top.f
+incdir+.
fc_pkg.sv
fc_ctrl.sv
fc_sram.sv
fc_feed.sv
fc_mac.sv
fc_post.sv
fc_argmax.sv
fc_top.sv
tb_fc_top.sv

// File: fc_top.sv
`timescale 1ns/10ps
`include "fc_cfg.svh"

module fc_top (
  input  logic                  clk,
  input  logic                  rstn,
  input  fc_pkg::word_t         s_tdata,
  input  logic                  s_tvalid,
  input  logic                  s_tlast,
  output logic                  s_tready,
  output fc_pkg::word_t         m_tdata,
  output logic                  m_tvalid,
  output logic                  m_tlast,
  input  logic                  m_tready,
  input  fc_pkg::cmd_t          command,
  input  logic                  fc_start,
  input  logic [`FC_SIZE_W-1:0] size,
  output logic                  f_writedone,
  output logic                  b_writedone,
  output logic                  w_writedone,
  output logic                  fc_done,
  output fc_pkg::idx_t          max_idx
);
  import fc_pkg::*;

  logic f_we;
  logic b_we;
  logic [`FC_LANES-1:0] w_we;
  logic mem_en;
  addr_t f_addr;
  addr_t b_addr;
  addr_t w_addr;
  word_t f_word;
  word_t b_word;
  word_t w_word [`FC_LANES];
  logic feed_load;
  logic feed_first;
  logic feed_last;
  logic feed_busy;
  logic last_group;
  logic compute_start;
  logic mac_valid;
  logic mac_first;
  logic mac_last;
  elem_t feat_byte;
  elem_t w_byte [`FC_LANES];
  acc_t acc [`FC_LANES];
  logic [`FC_LANES-1:0] lane_done;

  fc_ctrl u_ctrl (
    .clk(clk),
    .rstn(rstn),
    .command(command),
    .fc_start(fc_start),
    .size(size),
    .s_tvalid(s_tvalid),
    .m_tvalid(m_tvalid),
    .m_tready(m_tready),
    .feed_busy(feed_busy),
    .acc_done(lane_done[0]),
    .s_tready(s_tready),
    .f_writedone(f_writedone),
    .b_writedone(b_writedone),
    .w_writedone(w_writedone),
    .f_we(f_we),
    .b_we(b_we),
    .w_we(w_we),
    .mem_en(mem_en),
    .f_addr(f_addr),
    .b_addr(b_addr),
    .w_addr(w_addr),
    .feed_load(feed_load),
    .feed_first(feed_first),
    .feed_last(feed_last),
    .last_group(last_group),
    .compute_start(compute_start),
    .fc_done(fc_done)
  );

  fc_sram u_f_sram (
    .clk(clk),
    .en(mem_en),
    .we(f_we),
    .addr(f_addr),
    .din(s_tdata),
    .dout(f_word)
  );

  fc_sram u_b_sram (
    .clk(clk),
    .en(mem_en),
    .we(b_we),
    .addr(b_addr),
    .din(s_tdata),
    .dout(b_word)
  );

  fc_feed u_feed (
    .clk(clk),
    .rstn(rstn),
    .feed_load(feed_load),
    .feed_first(feed_first),
    .feed_last(feed_last),
    .f_word(f_word),
    .w_word0(w_word[0]),
    .w_word1(w_word[1]),
    .w_word2(w_word[2]),
    .w_word3(w_word[3]),
    .feed_busy(feed_busy),
    .mac_valid(mac_valid),
    .mac_first(mac_first),
    .mac_last(mac_last),
    .feat_byte(feat_byte),
    .w_byte0(w_byte[0]),
    .w_byte1(w_byte[1]),
    .w_byte2(w_byte[2]),
    .w_byte3(w_byte[3])
  );

  // One weight buffer and one MAC per output lane
  for (genvar i = 0; i < `FC_LANES; i++) begin : g_lane
    fc_sram u_w_sram (
      .clk(clk),
      .en(mem_en),
      .we(w_we[i]),
      .addr(w_addr),
      .din(s_tdata),
      .dout(w_word[i])
    );

    fc_mac u_mac (
      .clk(clk),
      .rstn(rstn),
      .mac_valid(mac_valid),
      .mac_first(mac_first),
      .mac_last(mac_last),
      .a(feat_byte),
      .b(w_byte[i]),
      .acc(acc[i]),
      .acc_done(lane_done[i])
    );
  end

  fc_post u_post (
    .clk(clk),
    .rstn(rstn),
    .acc_done(lane_done[0]),
    .acc0(acc[0]),
    .acc1(acc[1]),
    .acc2(acc[2]),
    .acc3(acc[3]),
    .bias_word(b_word),
    .last_group(last_group),
    .m_tready(m_tready),
    .m_tdata(m_tdata),
    .m_tvalid(m_tvalid),
    .m_tlast(m_tlast)
  );

  fc_argmax u_argmax (
    .clk(clk),
    .rstn(rstn),
    .compute_start(compute_start),
    .m_tvalid(m_tvalid),
    .m_tready(m_tready),
    .m_tdata(m_tdata),
    .max_idx(max_idx)
  );

endmodule

// File: tb_fc_top.sv
`timescale 1ns/10ps
`include "fc_cfg.svh"

module tb_fc_top;
  import fc_pkg::*;

  localparam int SEED = 51741;
  localparam int RUNS = 12;
  localparam int LOAD_LIMIT = 4000;
  localparam int SW = `FC_SIZE_W;

  logic clk;
  logic rstn;
  word_t s_tdata;
  logic s_tvalid;
  logic s_tlast;
  logic s_tready;
  word_t m_tdata;
  logic m_tvalid;
  logic m_tlast;
  logic m_tready;
  cmd_t command;
  logic fc_start;
  logic [`FC_SIZE_W-1:0] size;
  logic f_writedone;
  logic b_writedone;
  logic w_writedone;
  logic fc_done;
  idx_t max_idx;

  int mismatches;
  int faults;
  logic stalled;
  int n_in;
  int n_out;
  int amp;
  int feat [];
  int bias [];
  int wgt [];
  word_t tx_words [$];
  word_t exp_words [$];
  idx_t exp_max;

  fc_top dut0 (
    .clk(clk),
    .rstn(rstn),
    .s_tdata(s_tdata),
    .s_tvalid(s_tvalid),
    .s_tlast(s_tlast),
    .s_tready(s_tready),
    .m_tdata(m_tdata),
    .m_tvalid(m_tvalid),
    .m_tlast(m_tlast),
    .m_tready(m_tready),
    .command(command),
    .fc_start(fc_start),
    .size(size),
    .f_writedone(f_writedone),
    .b_writedone(b_writedone),
    .w_writedone(w_writedone),
    .fc_done(fc_done),
    .max_idx(max_idx)
  );

  always #50 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Checks and report
  ////////////////////////////////////////////////////////////
  task automatic check_word(string name, word_t exp, word_t act);
    if (exp !== act) begin
      mismatches++;
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_idx(string name, idx_t exp, idx_t act);
    if (exp !== act) begin
      mismatches++;
      $display("Mismatch %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_flag(string name, logic exp, logic act);
    if (exp !== act) begin
      mismatches++;
      $display("Mismatch %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic report_fault(string msg);
    faults++;
    $display("Error: %s", msg);
  endtask

  task automatic finish_run();
    $display("Result: %0d mismatches, %0d other errors", mismatches, faults);
    if (mismatches == 0 && faults == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  endtask

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////
  function automatic int rand_elem(int lim);
    return int'($urandom_range(2 * lim)) - lim;
  endfunction

  function automatic word_t pack4(int e0, int e1, int e2, int e3);
    return {e3[7:0], e2[7:0], e1[7:0], e0[7:0]};
  endfunction

  // ReLU, right shift, clamp to 127
  function automatic int relu_quant(int r);
    int s;
    if (r < 0) begin
      return 0;
    end
    s = r >>> `FC_OUT_SHIFT;
    if (s > 127) begin
      return 127;
    end
    return s;
  endfunction

  task automatic build_run();
    int sum;
    int q;
    int best;
    word_t w;
    n_in = 4 * (1 + int'($urandom_range(15)));
    n_out = 4 * (1 + int'($urandom_range(15)));
    // Small ranges land in the int8 window and large ones saturate
    case ($urandom_range(2))
      0: amp = 3;
      1: amp = 20;
      default: amp = 127;
    endcase
    feat = new[n_in];
    bias = new[n_out];
    wgt = new[n_in * n_out];
    foreach (feat[k]) feat[k] = rand_elem(amp);
    foreach (bias[j]) bias[j] = rand_elem(127);
    foreach (wgt[x]) wgt[x] = rand_elem(amp);
    exp_words.delete();
    exp_max = '0;
    best = -128;
    w = '0;
    for (int j = 0; j < n_out; j++) begin
      sum = bias[j];
      for (int k = 0; k < n_in; k++) begin
        sum += feat[k] * wgt[j * n_in + k];
      end
      q = relu_quant(sum);
      w[8 * (j % 4) +: 8] = q[7:0];
      // Ties go to the later output
      if (q >= best) begin
        best = q;
        exp_max = idx_t'(j);
      end
      if (j % 4 == 3) begin
        exp_words.push_back(w);
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////
  function automatic logic writedone_of(cmd_t cmd);
    if (cmd[CMD_FEAT]) begin
      return f_writedone;
    end
    if (cmd[CMD_BIAS]) begin
      return b_writedone;
    end
    return w_writedone;
  endfunction

  task automatic apply_reset();
    rstn <= 1'b0;
    repeat (8) @(posedge clk);
    check_flag("s_tready in reset", 1'b0, s_tready);
    check_flag("m_tvalid in reset", 1'b0, m_tvalid);
    check_flag("fc_done in reset", 1'b0, fc_done);
    check_flag("f_writedone in reset", 1'b0, f_writedone);
    check_flag("b_writedone in reset", 1'b0, b_writedone);
    check_flag("w_writedone in reset", 1'b0, w_writedone);
    rstn <= 1'b1;
  endtask

  task automatic load_stream(cmd_t cmd, int nbytes, string name);
    int taken;
    int cycles;
    taken = 0;
    cycles = 0;
    command <= cmd;
    size <= SW'(nbytes);
    fc_start <= 1'b1;
    @(posedge clk);
    fc_start <= 1'b0;
    command <= '0;
    s_tdata <= tx_words[0];
    s_tvalid <= ($urandom_range(3) != 0);
    while (taken < tx_words.size()) begin
      @(posedge clk);
      cycles++;
      if (cycles > LOAD_LIMIT) begin
        report_fault($sformatf("%s load stalled before all words were taken", name));
        stalled = 1'b1;
        return;
      end
      check_flag($sformatf("%s writedone during load", name), 1'b0, writedone_of(cmd));
      if (s_tvalid && s_tready) begin
        taken++;
      end
      if (taken < tx_words.size()) begin
        s_tdata <= tx_words[taken];
        // A word once offered stays until taken
        if (!s_tvalid || s_tready) begin
          s_tvalid <= ($urandom_range(3) != 0);
        end
      end else begin
        // Offer one extra word that must be refused
        s_tdata <= '1;
        s_tvalid <= 1'b1;
      end
    end
    @(posedge clk);
    check_flag($sformatf("%s s_tready after load", name), 1'b0, s_tready);
    check_flag($sformatf("%s writedone", name), 1'b1, writedone_of(cmd));
    s_tvalid <= 1'b0;
  endtask

  task automatic load_inputs();
    tx_words.delete();
    for (int k = 0; k < n_in; k += 4) begin
      tx_words.push_back(pack4(feat[k], feat[k + 1], feat[k + 2], feat[k + 3]));
    end
    load_stream(3'b001, n_in, "feature");
    if (stalled) begin
      return;
    end
    tx_words.delete();
    for (int j = 0; j < n_out; j += 4) begin
      tx_words.push_back(pack4(bias[j], bias[j + 1], bias[j + 2], bias[j + 3]));
    end
    load_stream(3'b010, n_out, "bias");
    if (stalled) begin
      return;
    end
    // One row per output neuron
    tx_words.delete();
    for (int x = 0; x < n_in * n_out; x += 4) begin
      tx_words.push_back(pack4(wgt[x], wgt[x + 1], wgt[x + 2], wgt[x + 3]));
    end
    load_stream(3'b100, n_in * n_out, "weight");
  endtask

  task automatic collect_outputs();
    int cycles;
    int limit;
    int grp;
    logic hold;
    logic done_due;
    logic finished;
    word_t held;
    cycles = 0;
    limit = 2000 + 8 * n_in * n_out;
    grp = 0;
    hold = 1'b0;
    done_due = 1'b0;
    finished = 1'b0;
    held = '0;
    while (!finished) begin
      @(posedge clk);
      cycles++;
      if (cycles > limit) begin
        report_fault("output stream did not finish in time");
        stalled = 1'b1;
        return;
      end
      if (hold && (!m_tvalid || m_tdata !== held)) begin
        report_fault("output word changed or dropped while stalled");
      end
      check_flag("fc_done", done_due, fc_done);
      if (done_due) begin
        check_idx("max_idx", exp_max, max_idx);
        finished = 1'b1;
      end
      done_due = 1'b0;
      if (m_tvalid && m_tready) begin
        if (grp >= exp_words.size()) begin
          report_fault("output word beyond the last group");
        end else begin
          check_word($sformatf("m_tdata group %0d", grp), exp_words[grp], m_tdata);
          check_flag($sformatf("m_tlast group %0d", grp),
                     grp == exp_words.size() - 1, m_tlast);
          done_due = (grp == exp_words.size() - 1);
        end
        grp++;
      end
      hold = m_tvalid && !m_tready;
      held = m_tdata;
      m_tready <= ($urandom_range(2) != 0);
    end
    repeat (4) begin
      @(posedge clk);
      check_flag("m_tvalid after done", 1'b0, m_tvalid);
      check_flag("fc_done after done", 1'b0, fc_done);
    end
    m_tready <= 1'b0;
  endtask

  initial begin
    void'($urandom(SEED));
    mismatches = 0;
    faults = 0;
    stalled = 1'b0;
    clk = 1'b0;
    rstn = 1'b0;
    s_tdata = '0;
    s_tvalid = 1'b0;
    s_tlast = 1'b0;
    m_tready = 1'b0;
    command = '0;
    fc_start = 1'b0;
    size = '0;
    for (int run = 0; run < RUNS; run++) begin
      build_run();
      $display("Run %0d: N_IN=%0d N_OUT=%0d range=%0d", run, n_in, n_out, amp);
      apply_reset();
      load_inputs();
      if (!stalled) begin
        collect_outputs();
      end
      if (stalled) begin
        break;
      end
    end
    finish_run();
  end

endmodule
